/* include/tile_defines.svh */
/*
 * Global sizing macros for the tile row-fetch front end
 * Include wherever a width or count is needed
 */
`ifndef TILE_DEFINES_SVH
`define TILE_DEFINES_SVH

// Tensor dimensions, the last one is the row itself
`define TILE_DIM 3
// Independent command channels sharing one memory
`define TILE_NCH 2

// Global linear address, compared as signed for clamping
`define TILE_ABW 12
// One row of data
`define TILE_DBW 16
// Pad amount per row
`define TILE_PBW 3

// Row memory, indexed by the low address bits
`define TILE_MEM_AW 10
`define TILE_MEM_DEPTH (1 << `TILE_MEM_AW)

`endif

/* hdl/tile_pkg.sv */
/*
 * Common types for the tile row-fetch blocks
 * Modules import it in their body and use scoped names in ports
 */
`include "tile_defines.svh"

package tile_pkg;

	// ============================================================
	// Vector types
	// ============================================================

	// Global address or linear offset
	typedef logic [`TILE_ABW-1:0] gaddr_t;
	// One row of memory data
	typedef logic [`TILE_DBW-1:0] rdata_t;
	// Row pad width
	typedef logic [`TILE_PBW-1:0] pad_t;
	// One bit per channel
	typedef logic [`TILE_NCH-1:0] ch_mask_t;

	// ============================================================
	// State machines
	// ============================================================

	// Row counter, waiting for a command or walking rows
	typedef enum logic {
		IDLE,
		RUN
	} cnt_state_e;

endpackage

/* hdl/row_offset_counter.sv */
/*
 * Multi-dimensional row counter for one chunk command
 * Takes end values and strides on src handshake, emits one position per dst handshake
 */
`timescale 1ns/10ps
`include "tile_defines.svh"

module row_offset_counter (
	input  logic                i_clk,
	input  logic                i_arst_n,
	input  logic                i_src_rdy,
	output logic                o_src_ack,
	input  tile_pkg::gaddr_t    i_end    [`TILE_DIM-1],
	input  tile_pkg::gaddr_t    i_stride [`TILE_DIM-1],
	output logic                o_dst_rdy,
	input  logic                i_dst_ack,
	output tile_pkg::gaddr_t    o_ofs    [`TILE_DIM-1],
	output logic [`TILE_DIM-2:0] o_sel_end,
	output logic                o_islast
);
	import tile_pkg::*;

	localparam int NDIM = `TILE_DIM - 1;

	cnt_state_e state;
	gaddr_t     end_r    [NDIM];
	gaddr_t     stride_r [NDIM];
	gaddr_t     cur      [NDIM];
	gaddr_t     cur_nxt  [NDIM];
	logic       src_take;
	logic       dst_take;

	// Command only taken while idle
	assign o_src_ack = (state == IDLE);
	assign o_dst_rdy = (state == RUN);
	assign src_take  = i_src_rdy && o_src_ack;
	assign dst_take  = o_dst_rdy && i_dst_ack;

	// End flags per outer dimension
	always_comb begin
		for (int d = 0; d < NDIM; d++) begin
			o_sel_end[d] = (cur[d] == end_r[d]);
			o_ofs[d]     = cur[d];
		end
	end
	// Last row when all dimensions sit at their end
	assign o_islast = &o_sel_end;

	// ============================================================
	// Next position, innermost outer dimension fastest
	// ============================================================
	always_comb begin : step_blk
		logic carry;
		carry = 1'b1;
		for (int d = NDIM - 1; d >= 0; d--) begin
			cur_nxt[d] = cur[d];
			if (carry) begin
				// Wrap to zero and pass the carry outward
				if (o_sel_end[d]) begin
					cur_nxt[d] = '0;
				end else begin
					cur_nxt[d] = cur[d] + stride_r[d];
					carry      = 1'b0;
				end
			end
		end
	end

	// Latch command limits
	always_ff @(posedge i_clk) begin
		if (src_take) begin
			end_r    <= i_end;
			stride_r <= i_stride;
		end
	end

	// State and position
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state <= IDLE;
			for (int d = 0; d < NDIM; d++) begin
				cur[d] <= '0;
			end
		end else begin
			unique case (state)
				IDLE: begin
					if (src_take) begin
						state <= RUN;
						for (int d = 0; d < NDIM; d++) begin
							cur[d] <= '0;
						end
					end
				end
				RUN: begin
					if (dst_take) begin
						// Back to idle once the final row is taken
						if (o_islast) state <= IDLE;
						else cur <= cur_nxt;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

/* hdl/chunk_row_start.sv */
/*
 * One channel: chunk command in, clamped linear row addresses out
 * Rows leave with validity, pad and last-row flag under a ready/ack handshake
 */
`timescale 1ns/10ps
`include "tile_defines.svh"

module chunk_row_start (
	input  logic             i_clk,
	input  logic             i_arst_n,
	input  logic             i_cmd_rdy,
	output logic             o_cmd_ack,
	input  tile_pkg::gaddr_t i_cmd_base,
	input  tile_pkg::gaddr_t i_cmd_ofs   [`TILE_DIM-1],
	input  tile_pkg::gaddr_t i_cmd_bound [`TILE_DIM],
	input  tile_pkg::gaddr_t i_cmd_last  [`TILE_DIM-1],
	input  tile_pkg::pad_t   i_cmd_pad   [`TILE_DIM-1],
	output logic             o_row_rdy,
	input  logic             i_row_ack,
	output tile_pkg::gaddr_t o_row_linear,
	output logic             o_row_valid,
	output tile_pkg::pad_t   o_row_pad,
	output logic             o_row_islast
);
	import tile_pkg::*;

	localparam int NDIM = `TILE_DIM - 1;

	// Registered command fields
	gaddr_t base_r;
	gaddr_t ofs_r   [NDIM];
	gaddr_t bound_r [`TILE_DIM];
	pad_t   pad_r   [NDIM];

	// Counter side
	gaddr_t           row_stride [NDIM];
	gaddr_t           cur_row    [NDIM];
	logic [NDIM-1:0]  sel_end;
	logic             cmd_take;

	// Clamp intermediates
	gaddr_t           unclamp [NDIM];
	gaddr_t           clamp   [NDIM];
	logic [NDIM-1:0]  dim_ok;

	assign cmd_take = i_cmd_rdy && o_cmd_ack;

	// Step of dimension d is the extent of d+1
	always_comb begin
		for (int d = 0; d < NDIM; d++) begin
			row_stride[d] = i_cmd_bound[d+1];
		end
	end

	always_ff @(posedge i_clk) begin
		if (cmd_take) begin
			base_r  <= i_cmd_base;
			ofs_r   <= i_cmd_ofs;
			bound_r <= i_cmd_bound;
			pad_r   <= i_cmd_pad;
		end
	end

	row_offset_counter u_cnt (
		.i_clk     (i_clk),
		.i_arst_n  (i_arst_n),
		.i_src_rdy (i_cmd_rdy),
		.o_src_ack (o_cmd_ack),
		.i_end     (i_cmd_last),
		.i_stride  (row_stride),
		.o_dst_rdy (o_row_rdy),
		.i_dst_ack (i_row_ack),
		.o_ofs     (cur_row),
		.o_sel_end (sel_end),
		.o_islast  (o_row_islast)
	);

	// ============================================================
	// Clamp each dimension and sum into the row address
	// ============================================================
	always_comb begin
		o_row_linear = base_r;
		o_row_pad    = '0;
		for (int d = 0; d < NDIM; d++) begin
			unclamp[d] = cur_row[d] + ofs_r[d];
			if (unclamp[d][`TILE_ABW-1]) begin
				// Before the tensor start
				clamp[d]  = '0;
				dim_ok[d] = 1'b0;
			end else if ($signed(unclamp[d]) >= $signed(bound_r[d])) begin
				// Past the end, hold on the last slice
				clamp[d]  = bound_r[d] - bound_r[d+1];
				dim_ok[d] = 1'b0;
			end else begin
				clamp[d]  = unclamp[d];
				dim_ok[d] = 1'b1;
			end
			o_row_linear = o_row_linear + clamp[d];
			// Pads of dimensions at their end
			if (sel_end[d]) o_row_pad = o_row_pad | pad_r[d];
		end
	end

	assign o_row_valid = &dim_ok;

endmodule

/* hdl/row_read_arbiter.sv */
/*
 * Round-robin arbiter for the shared row memory read port
 * One grant per cycle, the grant doubles as the row ack
 */
`timescale 1ns/10ps
`include "tile_defines.svh"

module row_read_arbiter (
	input  logic                              i_clk,
	input  logic                              i_arst_n,
	input  tile_pkg::ch_mask_t                i_req,
	input  tile_pkg::gaddr_t                  i_addr  [`TILE_NCH],
	input  logic                              i_valid [`TILE_NCH],
	output tile_pkg::ch_mask_t                o_gnt,
	output logic [`TILE_MEM_AW-1:0]           o_mem_addr,
	output logic                              o_mem_en,
	output logic                              o_mem_zero,
	output logic [$clog2(`TILE_NCH)-1:0]      o_gnt_ch
);

	localparam int NCH = `TILE_NCH;
	localparam int CHW = $clog2(`TILE_NCH);

	// Channel with highest priority this cycle
	logic [CHW-1:0] rr_ptr;

	// ============================================================
	// Pick the first requester starting at the pointer
	// ============================================================
	always_comb begin : pick_blk
		int   idx;
		logic found;
		found    = 1'b0;
		o_gnt    = '0;
		o_gnt_ch = rr_ptr;
		for (int i = 0; i < NCH; i++) begin
			idx = int'(rr_ptr) + i;
			if (idx >= NCH) idx = idx - NCH;
			if (!found && i_req[idx]) begin
				found    = 1'b1;
				o_gnt_ch = CHW'(idx);
			end
		end
		if (found) o_gnt[o_gnt_ch] = 1'b1;
	end

	// Read port follows the winner
	assign o_mem_en   = |o_gnt;
	assign o_mem_addr = i_addr[o_gnt_ch][`TILE_MEM_AW-1:0];
	// Out-of-tensor rows read as zero
	assign o_mem_zero = !i_valid[o_gnt_ch];

	// Priority moves just past the last winner
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			rr_ptr <= '0;
		end else if (o_mem_en) begin
			if (o_gnt_ch == CHW'(NCH - 1)) rr_ptr <= '0;
			else rr_ptr <= o_gnt_ch + 1'b1;
		end
	end

endmodule

/* hdl/row_memory.sv */
/*
 * Row storage with one synchronous read and one write port
 * Write port is for loading only, reads of invalid rows give zero
 */
`timescale 1ns/10ps
`include "tile_defines.svh"

module row_memory (
	input  logic                    i_clk,
	input  logic                    i_rd_en,
	input  logic [`TILE_MEM_AW-1:0] i_rd_addr,
	input  logic                    i_rd_zero,
	output tile_pkg::rdata_t        o_rd_data,
	input  logic                    i_wr_en,
	input  logic [`TILE_MEM_AW-1:0] i_wr_addr,
	input  tile_pkg::rdata_t        i_wr_data
);
	import tile_pkg::*;

	// ============================================================
	// Storage array
	// ============================================================
	rdata_t mem [`TILE_MEM_DEPTH];

	// Load path
	always_ff @(posedge i_clk) begin
		if (i_wr_en) begin
			mem[i_wr_addr] <= i_wr_data;
		end
	end

	// Read path, data valid one cycle after enable
	always_ff @(posedge i_clk) begin
		if (i_rd_en) begin
			// Clamped rows outside the tensor
			if (i_rd_zero) o_rd_data <= '0;
			else o_rd_data <= mem[i_rd_addr];
		end
	end

endmodule

/* hdl/tile_row_fetch.sv */
/*
 * Top of the row-fetch front end
 * Two command channels share one row memory through a round-robin arbiter
 * Each fetched row comes back as a one-cycle pulse on o_rd_vld
 */
`timescale 1ns/10ps
`include "tile_defines.svh"

module tile_row_fetch (
	input  logic                    i_clk,
	input  logic                    i_arst_n,
	input  tile_pkg::ch_mask_t      i_cmd_rdy,
	output tile_pkg::ch_mask_t      o_cmd_ack,
	input  tile_pkg::gaddr_t        i_cmd_base  [`TILE_NCH],
	input  tile_pkg::gaddr_t        i_cmd_ofs   [`TILE_NCH][`TILE_DIM-1],
	input  tile_pkg::gaddr_t        i_cmd_bound [`TILE_NCH][`TILE_DIM],
	input  tile_pkg::gaddr_t        i_cmd_last  [`TILE_NCH][`TILE_DIM-1],
	input  tile_pkg::pad_t          i_cmd_pad   [`TILE_NCH][`TILE_DIM-1],
	input  logic                    i_wr_en,
	input  logic [`TILE_MEM_AW-1:0] i_wr_addr,
	input  tile_pkg::rdata_t        i_wr_data,
	output tile_pkg::ch_mask_t      o_rd_vld,
	output tile_pkg::rdata_t        o_rd_data  [`TILE_NCH],
	output tile_pkg::pad_t          o_rd_pad   [`TILE_NCH],
	output logic                    o_rd_valid [`TILE_NCH],
	output logic                    o_rd_last  [`TILE_NCH]
);
	import tile_pkg::*;

	localparam int CHW = $clog2(`TILE_NCH);

	// Rows from the channels
	ch_mask_t row_rdy;
	ch_mask_t gnt;
	gaddr_t   row_linear [`TILE_NCH];
	logic     row_valid  [`TILE_NCH];
	pad_t     row_pad    [`TILE_NCH];
	logic     row_islast [`TILE_NCH];

	// Shared read port
	logic [`TILE_MEM_AW-1:0] mem_addr;
	logic                    mem_en;
	logic                    mem_zero;
	logic [CHW-1:0]          gnt_ch;
	rdata_t                  mem_data;

	// Row flags delayed to meet the memory data
	ch_mask_t rd_vld_q;
	pad_t     pad_q;
	logic     valid_q;
	logic     last_q;

	// ============================================================
	// Channels
	// ============================================================
	for (genvar c = 0; c < `TILE_NCH; c++) begin : g_ch
		chunk_row_start u_crs (
			.i_clk        (i_clk),
			.i_arst_n     (i_arst_n),
			.i_cmd_rdy    (i_cmd_rdy[c]),
			.o_cmd_ack    (o_cmd_ack[c]),
			.i_cmd_base   (i_cmd_base[c]),
			.i_cmd_ofs    (i_cmd_ofs[c]),
			.i_cmd_bound  (i_cmd_bound[c]),
			.i_cmd_last   (i_cmd_last[c]),
			.i_cmd_pad    (i_cmd_pad[c]),
			.o_row_rdy    (row_rdy[c]),
			.i_row_ack    (gnt[c]),
			.o_row_linear (row_linear[c]),
			.o_row_valid  (row_valid[c]),
			.o_row_pad    (row_pad[c]),
			.o_row_islast (row_islast[c])
		);

		// Data and flags fan out, o_rd_vld tells whose row it is
		assign o_rd_data[c]  = mem_data;
		assign o_rd_pad[c]   = pad_q;
		assign o_rd_valid[c] = valid_q;
		assign o_rd_last[c]  = last_q;
	end

	row_read_arbiter u_arb (
		.i_clk      (i_clk),
		.i_arst_n   (i_arst_n),
		.i_req      (row_rdy),
		.i_addr     (row_linear),
		.i_valid    (row_valid),
		.o_gnt      (gnt),
		.o_mem_addr (mem_addr),
		.o_mem_en   (mem_en),
		.o_mem_zero (mem_zero),
		.o_gnt_ch   (gnt_ch)
	);

	row_memory u_mem (
		.i_clk     (i_clk),
		.i_rd_en   (mem_en),
		.i_rd_addr (mem_addr),
		.i_rd_zero (mem_zero),
		.o_rd_data (mem_data),
		.i_wr_en   (i_wr_en),
		.i_wr_addr (i_wr_addr),
		.i_wr_data (i_wr_data)
	);

	// ============================================================
	// One-cycle alignment with memory data
	// ============================================================
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) rd_vld_q <= '0;
		else rd_vld_q <= gnt;
	end

	// Flags of the granted row
	always_ff @(posedge i_clk) begin
		if (mem_en) begin
			pad_q   <= row_pad[gnt_ch];
			valid_q <= row_valid[gnt_ch];
			last_q  <= row_islast[gnt_ch];
		end
	end

	assign o_rd_vld = rd_vld_q;

endmodule

/* sim/tb_clock_gen.sv */
/*
 * Testbench clock and reset source
 * 40 ns clock, reset held low over the first two rising edges
 */
`timescale 1ns/10ps

module tb_clock_gen (
	output logic o_clk,
	output logic o_arst_n
);

	// Free-running clock, 20 ns per half period
	initial begin
		o_clk = 1'b0;
		forever begin
			#20 o_clk = ~o_clk;
		end
	end

	// Release 1 ns after the second rising edge
	initial begin
		o_arst_n = 1'b0;
		repeat (2) @(posedge o_clk);
		#1;
		o_arst_n = 1'b1;
	end

endmodule

/* sim/tile_row_fetch_tb.sv */
/*
 * Testbench for the tile row-fetch front end
 * Preloads the row memory, applies a table of chunk commands and checks each returned row
 */
`timescale 1ns/10ps
`include "tile_defines.svh"

module tile_row_fetch_tb;
	import tile_pkg::*;

	localparam int NCH   = `TILE_NCH;
	localparam int NDIM  = `TILE_DIM - 1;
	localparam int NTEST = 7;
	localparam int TMO   = 300;

	// Pair flag starts this command in the same cycle as the next entry
	typedef struct packed {
		logic [7:0]             ch;
		logic                   pair;
		logic                   rewrite;
		gaddr_t                 base;
		gaddr_t [NDIM-1:0]      ofs;
		gaddr_t [`TILE_DIM-1:0] bound;
		gaddr_t [NDIM-1:0]      last;
		pad_t [NDIM-1:0]        pad;
		logic [7:0]             nrows;
	} cmd_ent_t;

	// Predicted row as it should come back
	typedef struct packed {
		logic [7:0] ch;
		rdata_t     data;
		pad_t       pad;
		logic       valid;
		logic       last;
	} row_exp_t;

	logic clk;
	logic arst_n;

	// DUT inputs
	ch_mask_t                i_cmd_rdy;
	gaddr_t                  i_cmd_base  [NCH];
	gaddr_t                  i_cmd_ofs   [NCH][NDIM];
	gaddr_t                  i_cmd_bound [NCH][`TILE_DIM];
	gaddr_t                  i_cmd_last  [NCH][NDIM];
	pad_t                    i_cmd_pad   [NCH][NDIM];
	logic                    i_wr_en;
	logic [`TILE_MEM_AW-1:0] i_wr_addr;
	rdata_t                  i_wr_data;

	// DUT outputs
	ch_mask_t o_cmd_ack;
	ch_mask_t o_rd_vld;
	rdata_t   o_rd_data  [NCH];
	pad_t     o_rd_pad   [NCH];
	logic     o_rd_valid [NCH];
	logic     o_rd_last  [NCH];

	// Stimulus table, memory mirror and pending rows
	cmd_ent_t    tbl   [NTEST];
	string       tname [NTEST];
	int          n_ent;
	rdata_t      mirror [`TILE_MEM_DEPTH];
	row_exp_t    exp_q [$];
	logic [31:0] lfsr;
	int          n_checks;
	int          n_errors;
	int          rows_seen;

	tb_clock_gen u_clk (
		.o_clk    (clk),
		.o_arst_n (arst_n)
	);

	tile_row_fetch u_dut (
		.i_clk       (clk),
		.i_arst_n    (arst_n),
		.i_cmd_rdy   (i_cmd_rdy),
		.o_cmd_ack   (o_cmd_ack),
		.i_cmd_base  (i_cmd_base),
		.i_cmd_ofs   (i_cmd_ofs),
		.i_cmd_bound (i_cmd_bound),
		.i_cmd_last  (i_cmd_last),
		.i_cmd_pad   (i_cmd_pad),
		.i_wr_en     (i_wr_en),
		.i_wr_addr   (i_wr_addr),
		.i_wr_data   (i_wr_data),
		.o_rd_vld    (o_rd_vld),
		.o_rd_data   (o_rd_data),
		.o_rd_pad    (o_rd_pad),
		.o_rd_valid  (o_rd_valid),
		.o_rd_last   (o_rd_last)
	);

	// ============================================================
	// Helpers
	// ============================================================

	task automatic compare_val(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("error %s got %h expected %h", name, got, exp);
		end
	endtask

	// Fibonacci LFSR with taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	// One step per data bit
	task automatic draw_word(output rdata_t w);
		for (int b = 0; b < `TILE_DBW; b++) begin
			lfsr = lfsr_step(lfsr);
			w[b] = lfsr[0];
		end
	endtask

	// Called 2 ns after an edge and returns 2 ns after the write edge
	task automatic write_word(input int a, input rdata_t w);
		i_wr_en   = 1'b1;
		i_wr_addr = a[`TILE_MEM_AW-1:0];
		i_wr_data = w;
		mirror[a] = w;
		@(posedge clk);
		#2;
		i_wr_en = 1'b0;
	endtask

	task automatic fill_range(input int lo, input int hi);
		rdata_t w;
		for (int a = lo; a <= hi; a++) begin
			draw_word(w);
			// Address folded in so each word depends on all of it
			write_word(a, w ^ rdata_t'(a));
		end
	endtask

	task automatic add_cmd(input string nm, input int ch, input logic pair, input logic rw,
			input int base, input int o0, input int o1, input int b0, input int b1,
			input int b2, input int l0, input int l1, input int p0, input int p1,
			input int nrows);
		cmd_ent_t e;
		e.ch       = 8'(ch);
		e.pair     = pair;
		e.rewrite  = rw;
		e.base     = gaddr_t'(base);
		e.ofs[0]   = gaddr_t'(o0);
		e.ofs[1]   = gaddr_t'(o1);
		e.bound[0] = gaddr_t'(b0);
		e.bound[1] = gaddr_t'(b1);
		e.bound[2] = gaddr_t'(b2);
		e.last[0]  = gaddr_t'(l0);
		e.last[1]  = gaddr_t'(l1);
		e.pad[0]   = pad_t'(p0);
		e.pad[1]   = pad_t'(p1);
		e.nrows    = 8'(nrows);
		tbl[n_ent]   = e;
		tname[n_ent] = nm;
		n_ent++;
	endtask

	// ============================================================
	// Reference model applying the counting and clamp rules per row
	// ============================================================
	task automatic build_rows(input int t, output int n);
		cmd_ent_t e;
		row_exp_t r;
		int       cur [NDIM];
		int       u;
		int       cl;
		int       lin;
		logic     ok;
		e = tbl[t];
		n = 0;
		// Inner outer dimension changes fastest
		for (int c0 = 0; c0 <= int'(e.last[0]); c0 += int'(e.bound[1])) begin
			for (int c1 = 0; c1 <= int'(e.last[1]); c1 += int'(e.bound[2])) begin
				cur[0] = c0;
				cur[1] = c1;
				lin    = int'(e.base);
				ok     = 1'b1;
				r.pad  = '0;
				r.last = 1'b1;
				for (int d = 0; d < NDIM; d++) begin
					u = cur[d] + int'($signed(e.ofs[d]));
					if (u < 0) begin
						cl = 0;
						ok = 1'b0;
					end else if (u >= int'(e.bound[d])) begin
						// Held on the final slice of d
						cl = int'(e.bound[d]) - int'(e.bound[d+1]);
						ok = 1'b0;
					end else begin
						cl = u;
					end
					lin = lin + cl;
					if (cur[d] == int'(e.last[d])) r.pad = r.pad | e.pad[d];
					else r.last = 1'b0;
				end
				r.ch    = e.ch;
				r.valid = ok;
				r.data  = ok ? mirror[lin % `TILE_MEM_DEPTH] : '0;
				exp_q.push_back(r);
				n++;
			end
		end
	endtask

	task automatic drive_cmd(input int t);
		cmd_ent_t e;
		int       c;
		e = tbl[t];
		c = int'(e.ch);
		i_cmd_base[c] = e.base;
		for (int d = 0; d < NDIM; d++) begin
			i_cmd_ofs[c][d]  = e.ofs[d];
			i_cmd_last[c][d] = e.last[d];
			i_cmd_pad[c][d]  = e.pad[d];
		end
		for (int d = 0; d < `TILE_DIM; d++) begin
			i_cmd_bound[c][d] = e.bound[d];
		end
		i_cmd_rdy[c] = 1'b1;
	endtask

	// ============================================================
	// Bounded waits sampled 2 ns after the edge
	// ============================================================
	task automatic reset_release(output logic ok);
		int n;
		n = 0;
		while (!arst_n && n < TMO) begin
			@(posedge clk);
			#2;
			n++;
		end
		ok = arst_n;
		if (!ok) begin
			n_errors++;
			$display("reset was never released");
		end
	endtask

	task automatic ack_ready(input ch_mask_t m, output logic ok);
		int n;
		n = 0;
		while ((o_cmd_ack & m) != m && n < TMO) begin
			@(posedge clk);
			#2;
			n++;
		end
		ok = ((o_cmd_ack & m) == m);
		if (!ok) begin
			n_errors++;
			$display("timed out waiting for command ack, channel mask %b", m);
		end
	endtask

	// All predicted rows back and the channels idle again
	task automatic drain_rows(input ch_mask_t m, output logic ok);
		int n;
		n = 0;
		while (!(exp_q.size() == 0 && (o_cmd_ack & m) == m) && n < TMO) begin
			@(posedge clk);
			#2;
			n++;
		end
		ok = (exp_q.size() == 0 && (o_cmd_ack & m) == m);
		if (!ok) begin
			n_errors++;
			$display("timed out waiting for rows, channel mask %b, %0d rows missing", m,
				exp_q.size());
		end
	endtask

	// ============================================================
	// Row monitor on the falling edge
	// ============================================================
	always @(negedge clk) begin : monitor_blk
		row_exp_t e;
		int       idx;
		if (arst_n) begin
			if ($countones(o_rd_vld) > 1) begin
				n_errors++;
				$display("more than one channel returned a row in the same cycle");
			end
			for (int c = 0; c < NCH; c++) begin
				if (o_rd_vld[c]) begin
					rows_seen++;
					// Oldest pending row of this channel
					idx = -1;
					for (int i = exp_q.size() - 1; i >= 0; i--) begin
						if (int'(exp_q[i].ch) == c) idx = i;
					end
					if (idx < 0) begin
						n_errors++;
						$display("channel %0d returned a row that was not expected", c);
					end else begin
						e = exp_q[idx];
						exp_q.delete(idx);
						compare_val($sformatf("o_rd_data[%0d]", c), 32'(o_rd_data[c]),
							32'(e.data));
						compare_val($sformatf("o_rd_pad[%0d]", c), 32'(o_rd_pad[c]),
							32'(e.pad));
						compare_val($sformatf("o_rd_valid[%0d]", c), 32'(o_rd_valid[c]),
							32'(e.valid));
						compare_val($sformatf("o_rd_last[%0d]", c), 32'(o_rd_last[c]),
							32'(e.last));
					end
				end
			end
		end
	end

	// ============================================================
	// Main sequence
	// ============================================================
	initial begin : main_blk
		int       t;
		int       k;
		int       n;
		int       rows_exp;
		int       err0;
		int       seen0;
		int       n_tests;
		int       n_bad;
		ch_mask_t m;
		logic     ok;
		i_cmd_rdy = '0;
		i_wr_en   = 1'b0;
		i_wr_addr = '0;
		i_wr_data = '0;
		for (int c = 0; c < NCH; c++) begin
			i_cmd_base[c] = '0;
			for (int d = 0; d < NDIM; d++) begin
				i_cmd_ofs[c][d]  = '0;
				i_cmd_last[c][d] = '0;
				i_cmd_pad[c][d]  = '0;
			end
			for (int d = 0; d < `TILE_DIM; d++) begin
				i_cmd_bound[c][d] = '0;
			end
		end
		n_checks  = 0;
		n_errors  = 0;
		rows_seen = 0;
		n_tests   = 0;
		n_bad     = 0;
		n_ent     = 0;
		lfsr      = 32'hd5eb6353;

		// name ch pair rewrite base ofs0 ofs1 bound0..2 last0 last1 pad0 pad1 rows
		add_cmd("inbounds", 0, 0, 0, 100, 40, 8, 160, 40, 8, 80, 16, 1, 4, 9);
		add_cmd("clamp_neg", 1, 0, 0, 200, -40, -8, 160, 40, 8, 40, 8, 2, 1, 4);
		add_cmd("clamp_high", 0, 0, 0, 300, 120, 32, 160, 40, 8, 40, 8, 6, 3, 4);
		add_cmd("pad_or", 1, 0, 0, 50, 0, 0, 96, 24, 6, 72, 18, 3, 6, 16);
		add_cmd("dual", 0, 1, 0, 400, 0, 0, 160, 40, 8, 40, 24, 5, 2, 8);
		add_cmd("dual", 1, 0, 0, 600, 8, -8, 160, 40, 8, 80, 16, 1, 6, 9);
		add_cmd("rewrite", 0, 0, 1, 100, 40, 8, 160, 40, 8, 80, 16, 1, 4, 9);

		reset_release(ok);
		if (ok) begin
			// Idle state right out of reset
			compare_val("o_rd_vld", 32'(o_rd_vld), 32'h0);
			compare_val("o_cmd_ack", 32'(o_cmd_ack), 32'((1 << NCH) - 1));
			n_tests++;
			if (n_errors != 0) n_bad++;
			$display("test 0 reset: %s", (n_errors == 0) ? "ok" : "FAILED");
			fill_range(0, `TILE_MEM_DEPTH - 1);
		end

		t = 0;
		while (ok && t < n_ent) begin
			err0     = n_errors;
			seen0    = rows_seen;
			rows_exp = 0;
			m        = '0;
			if (tbl[t].rewrite) fill_range(128, 255);
			// Paired entries go out in the same cycle
			k = t;
			while (k < n_ent - 1 && tbl[k].pair) k++;
			for (int i = t; i <= k; i++) begin
				build_rows(i, n);
				compare_val("row count", 32'(n), 32'(tbl[i].nrows));
				rows_exp = rows_exp + int'(tbl[i].nrows);
				m = m | ch_mask_t'(1 << int'(tbl[i].ch));
			end
			ack_ready(m, ok);
			if (ok) begin
				for (int i = t; i <= k; i++) begin
					drive_cmd(i);
				end
				@(posedge clk);
				#2;
				i_cmd_rdy = '0;
				drain_rows(m, ok);
			end
			compare_val("rows returned", 32'(rows_seen - seen0), 32'(rows_exp));
			n_tests++;
			if (n_errors != err0) n_bad++;
			$display("test %0d %s: %s, %0d rows", t + 1, tname[t],
				(n_errors == err0) ? "ok" : "FAILED", rows_seen - seen0);
			t = k + 1;
		end

		$display("tests %0d, failed tests %0d, checks %0d, errors %0d",
			n_tests, n_bad, n_checks, n_errors);
		if (n_errors == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

/* files.f */
+incdir+include
hdl/tile_pkg.sv
hdl/row_offset_counter.sv
hdl/chunk_row_start.sv
hdl/row_read_arbiter.sv
hdl/row_memory.sv
hdl/tile_row_fetch.sv
sim/tb_clock_gen.sv
sim/tile_row_fetch_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the tile row-fetch simulation with Verilator
# Exit status is nonzero when the build, the run or the checks fail

cd "$(dirname "$0")" || exit 1

TOP=tile_row_fetch_tb
LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module "$TOP" -f files.f -o "$TOP"
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi

if grep -q "sim failed" "$LOG"; then
	echo "checks failed, see $LOG"
	exit 1
fi

exit 0
